//--- Bender.yml
package:
  name: xt_chipset

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/xt_bus_pkg.sv
      - verilog/xt_dma_pkg.sv
      - verilog/xt_bus_if.sv
      - verilog/refresh_timer.sv
      - verilog/dma_arbiter.sv
      - verilog/ready_sync.sv
      - verilog/data_bus_steer.sv
      - verilog/xt_chipset.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/xt_chipset_sva.sv
      - dv/tb_xt_chipset.sv

//--- dv/tb_xt_chipset.sv
// Data-driven testbench for the XT bus-control core
// Reads one operation per line from the testdata file and checks timer, steering, DMA and ready
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module tb_xt_chipset;
    import xt_bus_pkg::*;
    import xt_dma_pkg::*;

    logic clock;
    logic reset;
    addr_t address;
    data_t data_bus_in;
    logic io_read_n;
    logic io_write_n;
    logic memory_read_n;
    logic memory_write_n;
    logic io_channel_ready;
    dma_vec_t dma_request;
    data_t data_bus_out;
    logic data_bus_direction;
    logic processor_ready;
    dma_vec_t dma_acknowledge_n;
    logic address_enable_n;
    logic timer_out;

    int data_errors;
    int ack_errors;
    int bit_errors;
    int assert_errors;
    int cycle_count;
    int load_cycle;
    data_t reload_value;

    xt_chipset dut_i
    (
        .clock              (clock),
        .reset              (reset),
        .address            (address),
        .data_bus_in        (data_bus_in),
        .io_read_n          (io_read_n),
        .io_write_n         (io_write_n),
        .memory_read_n      (memory_read_n),
        .memory_write_n     (memory_write_n),
        .io_channel_ready   (io_channel_ready),
        .dma_request        (dma_request),
        .data_bus_out       (data_bus_out),
        .data_bus_direction (data_bus_direction),
        .processor_ready    (processor_ready),
        .dma_acknowledge_n  (dma_acknowledge_n),
        .address_enable_n   (address_enable_n),
        .timer_out          (timer_out)
    );

    always #20 clock = ~clock;

    always @(posedge clock)
        cycle_count <= cycle_count + 1;

    task automatic check_data(string name, data_t got, data_t exp);
        if (got !== exp)
        begin
            data_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_ack(string name, dma_vec_t got, dma_vec_t exp);
        if (got !== exp)
        begin
            ack_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            bit_errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Verification failed");
        $finish;
    endtask

    // Acknowledge pattern for the winning channel, lowest set request bit
    function automatic dma_vec_t priority_ack(dma_vec_t req);
        dma_vec_t lowest;
        lowest = req & (~req + 1'b1);
        return ~lowest;
    endfunction

    task automatic idle_cycle();
        @(posedge clock);
        io_read_n     <= 1'b1;
        io_write_n    <= 1'b1;
        memory_read_n <= 1'b1;
        data_bus_in   <= data_t'($urandom);
        @(negedge clock);
        check_data("data_bus_out idle", data_bus_out, '0);
        check_bit("data_bus_direction idle", data_bus_direction, 1'b0);
    endtask

    task automatic set_ready(logic level, logic exp);
        @(posedge clock);
        io_channel_ready <= level;
        @(negedge clock);
        check_bit("processor_ready early", processor_ready, ~exp);
        @(negedge clock);
        @(negedge clock);
        check_bit("processor_ready", processor_ready, exp);
    endtask

    task automatic timer_write(addr_t a, data_t d, data_t pulses);
        int seen;
        logic prev_ack;
        @(posedge clock);
        address    <= a;
        data_bus_in <= d;
        io_write_n <= 1'b0;
        @(posedge clock);
        io_write_n <= 1'b1;
        @(negedge clock);
        load_cycle   = cycle_count;
        reload_value = d;
        if (pulses != 0)
        begin
            seen = 0;
            prev_ack = dma_acknowledge_n[0];
            repeat (20 * (int'(d) + 1))
            begin
                @(negedge clock);
                if (prev_ack && !dma_acknowledge_n[0])
                    seen++;
                prev_ack = dma_acknowledge_n[0];
            end
            check_bit("refresh pulse count within one",
                      (seen >= int'(pulses) - 1) && (seen <= int'(pulses) + 1), 1'b1);
        end
    endtask

    task automatic timer_read(addr_t a, data_t limit);
        data_t model;
        @(posedge clock);
        address   <= a;
        io_read_n <= 1'b0;
        @(negedge clock);
        // Count restarts at the reload value every reload+1 clocks
        model = reload_value - data_t'((cycle_count - load_cycle) % (int'(reload_value) + 1));
        check_data("data_bus_out timer", data_bus_out, model);
        check_bit("timer count in range", data_bus_out <= limit, 1'b1);
        check_bit("data_bus_direction timer", data_bus_direction, 1'b0);
        @(posedge clock);
        io_read_n <= 1'b1;
    endtask

    task automatic external_read(addr_t a, data_t d, data_t exp);
        @(posedge clock);
        address       <= a;
        data_bus_in   <= d;
        memory_read_n <= 1'b0;
        @(negedge clock);
        check_data("data_bus_out external", data_bus_out, exp);
        check_bit("data_bus_direction external", data_bus_direction, 1'b1);
        idle_cycle();
    endtask

    task automatic observe_grant(dma_vec_t exp);
        int timeout;
        int length;
        dma_vec_t first;
        timeout = 0;
        while (&dma_acknowledge_n)
        begin
            @(negedge clock);
            timeout++;
            if (timeout > 50)
                abort_run("Timed out waiting for a DMA acknowledge");
        end
        first = dma_acknowledge_n;
        check_ack("dma_acknowledge_n", first, exp);
        length = 0;
        while (dma_acknowledge_n == first)
        begin
            check_bit("processor_ready in grant", processor_ready, 1'b0);
            check_bit("address_enable_n in grant", address_enable_n, 1'b0);
            length++;
            @(negedge clock);
            if (length > 20)
                abort_run("Timed out waiting for the end of a DMA grant");
        end
        check_data("grant clocks", data_t'(length), data_t'(`XT_DMA_CYCLES));
    endtask

    task automatic dma_sequence(dma_vec_t req, dma_vec_t exp);
        dma_vec_t remaining;
        // Requests raised during a CPU cycle must wait
        @(posedge clock);
        address     <= 20'h00100;
        io_read_n   <= 1'b0;
        dma_request <= req;
        repeat (5)
        begin
            @(negedge clock);
            check_ack("dma_acknowledge_n during CPU cycle", dma_acknowledge_n, '1);
        end
        @(posedge clock);
        io_read_n <= 1'b1;
        @(negedge clock);
        observe_grant(exp);
        remaining = req & exp;
        remaining[0] = 1'b0;
        @(posedge clock);
        dma_request <= remaining;
        @(negedge clock);
        observe_grant(priority_ack(remaining));
        @(posedge clock);
        dma_request <= '0;
    endtask

    initial
    begin
        int fd;
        int n;
        string line;
        string op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] e;

        void'($urandom(70));
        clock = 1'b0;
        reset = 1'b1;
        address = '0;
        data_bus_in = '0;
        io_read_n = 1'b1;
        io_write_n = 1'b1;
        memory_read_n = 1'b1;
        memory_write_n = 1'b1;
        io_channel_ready = 1'b0;
        dma_request = '0;
        cycle_count = 0;
        load_cycle = 0;
        reload_value = 8'hFF;
        data_errors = 0;
        ack_errors = 0;
        bit_errors = 0;
        assert_errors = 0;

        repeat (5) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_bit("timer_out", timer_out, 1'b0);
        check_ack("dma_acknowledge_n", dma_acknowledge_n, '1);
        check_bit("address_enable_n", address_enable_n, 1'b1);
        check_bit("processor_ready", processor_ready, 1'b0);
        check_bit("data_bus_direction", data_bus_direction, 1'b0);

        fd = $fopen("dv/xt_chipset_testdata.txt", "r");
        if (fd == 0)
            abort_run("Could not open the stimulus file");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() < 2) || (line[0] == "#"))
                continue;
            n = $sscanf(line, "%s %h %h %h", op, a, d, e);
            if (n != 4)
                continue;
            if (op == "ready")
                set_ready(d[0], e[0]);
            else if (op == "io_write")
                timer_write(addr_t'(a), data_t'(d), data_t'(e));
            else if (op == "io_read")
                timer_read(addr_t'(a), data_t'(e));
            else if (op == "ext_read")
                external_read(addr_t'(a), data_t'(d), data_t'(e));
            else if (op == "dma_req")
                dma_sequence(dma_vec_t'(d), dma_vec_t'(e));
            else
                $display("Unknown operation %s in stimulus file", op);
            idle_cycle();
        end
        $fclose(fd);

        assert_errors = dut_i.u_dma_arbiter.arb_sva_i.fail_count +
                        dut_i.u_ready_sync.ready_sva_i.fail_count;
        $display("Errors: data %0d, acknowledge %0d, bit %0d, assertion %0d",
                 data_errors, ack_errors, bit_errors, assert_errors);
        if ((data_errors + ack_errors + bit_errors + assert_errors) == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

//--- dv/xt_chipset_sva.sv
// Concurrent checks on DMA ownership and processor ready
// Bound into the arbiter and the ready block with unused inputs tied inactive
`timescale 1ns/1ns

module xt_chipset_sva
(
    input   logic                   clock,
    input   logic                   reset,
    input   xt_dma_pkg::dma_vec_t   dma_acknowledge_n,
    input   logic                   address_enable_n,
    input   logic                   dma_wait,
    input   logic                   processor_ready
);
    import xt_dma_pkg::*;

    int fail_count = 0;

    // One channel owns the bus at a time
    one_ack_low: assert property (@(posedge clock) disable iff (reset)
        $onehot0(~dma_acknowledge_n))
        else
        begin
            fail_count++;
            $error("more than one DMA acknowledge low");
        end

    aen_follows_ack: assert property (@(posedge clock) disable iff (reset)
        address_enable_n == (&dma_acknowledge_n))
        else
        begin
            fail_count++;
            $error("address_enable_n does not match the acknowledges");
        end

    // Registered hold keeps ready low one clock past the end of DMA
    ready_held_in_dma: assert property (@(posedge clock) disable iff (reset)
        (dma_wait || $past(dma_wait)) |-> !processor_ready)
        else
        begin
            fail_count++;
            $error("processor_ready high while DMA holds the bus");
        end

endmodule

bind dma_arbiter xt_chipset_sva arb_sva_i
(
    .clock              (clock),
    .reset              (reset),
    .dma_acknowledge_n  (dma_acknowledge_n),
    .address_enable_n   (address_enable_n),
    .dma_wait           (dma_wait),
    .processor_ready    (1'b0)
);

bind ready_sync xt_chipset_sva ready_sva_i
(
    .clock              (clock),
    .reset              (reset),
    .dma_acknowledge_n  ('1),
    .address_enable_n   (1'b1),
    .dma_wait           (dma_wait),
    .processor_ready    (processor_ready)
);

//--- dv/xt_chipset_testdata.txt
# operation address(hex) data(hex) expected(hex)
# io_write expected = refresh pulses in 20*(reload+1) clocks, 0 skips the count
ready 00000 01 01
dma_req 00000 0a 0d
ext_read 12345 5a 5a
ext_read 80000 a5 a5
ext_read 00041 3c 3c
io_write 00041 07 0a
io_read 00041 00 07
io_read 00041 00 07
io_write 00041 20 00
io_read 00041 00 20
io_read 00041 00 20
ext_read 00200 c3 c3

//--- flist.f
+incdir+verilog
verilog/xt_bus_pkg.sv
verilog/xt_dma_pkg.sv
verilog/xt_bus_if.sv
verilog/refresh_timer.sv
verilog/dma_arbiter.sv
verilog/ready_sync.sv
verilog/data_bus_steer.sv
verilog/xt_chipset.sv
dv/xt_chipset_sva.sv
dv/tb_xt_chipset.sv

//--- verilog/data_bus_steer.sv
// Read-back data steering for the CPU data bus
// Chipset registers win over the external bus, combinational path
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module data_bus_steer
(
    xt_bus_if.steer_mp          bus,
    input   xt_bus_pkg::data_t  chip_read_data,
    input   logic               chip_read_valid,
    input   xt_bus_pkg::data_t  data_bus_in,
    output  xt_bus_pkg::data_t  data_bus_out,
    output  logic               data_bus_direction
);
    import xt_bus_pkg::*;

    logic   ext_read;

    // Reads that the chipset does not claim go out to the external bus
    assign ext_read = cmd_is_read(bus.cmd) &&
                      !((bus.cmd == CMD_IO_READ) &&
                        (bus.address == addr_t'(`XT_TIMER_PORT)));

    always_comb
    begin
        if (chip_read_valid)
        begin
            data_bus_out       = chip_read_data;
            data_bus_direction = 1'b0;
        end
        else if (ext_read)
        begin
            data_bus_out       = data_bus_in;
            data_bus_direction = 1'b1;
        end
        else
        begin
            data_bus_out       = '0;
            data_bus_direction = 1'b0;
        end
    end

endmodule

//--- verilog/dma_arbiter.sv
// Fixed-priority DMA arbiter, channel 0 wins
// A grant starts only between CPU cycles and lasts XT_DMA_CYCLES clocks,
// followed by one release clock
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module dma_arbiter
(
    input   logic                   clock,
    input   logic                   reset,
    xt_bus_if.arb_mp                bus,
    input   xt_dma_pkg::dma_vec_t   dma_request,
    output  xt_dma_pkg::dma_vec_t   dma_acknowledge_n,
    output  logic                   address_enable_n,
    output  logic                   dma_wait
);
    import xt_bus_pkg::*;
    import xt_dma_pkg::*;

    localparam int unsigned CNT_W = $clog2(`XT_DMA_CYCLES);
    localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(`XT_DMA_CYCLES - 1);

    dma_state_t         state;
    dma_chan_t          grant_chan;
    dma_chan_t          next_chan;
    logic [CNT_W-1:0]   cycle_count;

    // Lowest-numbered request wins
    always_comb
    begin
        next_chan = '0;
        for (int i = `XT_DMA_CH - 1; i >= 0; i--)
        begin
            if (dma_request[i])
                next_chan = dma_chan_t'(i);
        end
    end

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            state       <= DMA_IDLE;
            grant_chan  <= '0;
            cycle_count <= '0;
        end
        else
        begin
            case (state)
                DMA_IDLE:
                begin
                    // CPU cycle in progress holds off the request
                    if ((bus.cmd == CMD_IDLE) && (|dma_request))
                    begin
                        state       <= DMA_GRANT;
                        grant_chan  <= next_chan;
                        cycle_count <= '0;
                    end
                end
                DMA_GRANT:
                begin
                    if (cycle_count == LAST_CYCLE)
                        state <= DMA_RELEASE;
                    else
                        cycle_count <= cycle_count + 1'b1;
                end
                default:
                    state <= DMA_IDLE;
            endcase
        end
    end

    always_comb
    begin
        dma_acknowledge_n = '1;
        if (state == DMA_GRANT)
            dma_acknowledge_n[grant_chan] = 1'b0;
    end

    assign address_enable_n = (state != DMA_GRANT);
    assign dma_wait         = (state != DMA_IDLE);

endmodule

//--- verilog/ready_sync.sv
// Builds processor_ready from the channel ready line
// Ready passes through an XT_READY_SYNC-deep synchronizer and is held low around DMA
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module ready_sync
(
    input   logic   clock,
    input   logic   reset,
    input   logic   io_channel_ready,
    input   logic   dma_wait,
    output  logic   processor_ready
);

    logic   [`XT_READY_SYNC-1:0]    ready_sync_q;
    logic                           dma_free;

    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            ready_sync_q <= '0;
            dma_free     <= 1'b0;
        end
        else
        begin
            ready_sync_q <= {ready_sync_q[`XT_READY_SYNC-2:0], io_channel_ready};
            dma_free     <= ~dma_wait;
        end
    end

    // The registered term stretches the hold one clock past the release;
    // the direct term covers the first grant clock
    assign processor_ready = ready_sync_q[`XT_READY_SYNC-1] & dma_free & ~dma_wait;

endmodule

//--- verilog/refresh_timer.sv
// Reloadable refresh timer on I/O port XT_TIMER_PORT
// Toggles timer_out at each terminal count and requests DMA channel 0 on its rising edge
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module refresh_timer
(
    input   logic               clock,
    input   logic               reset,
    xt_bus_if.timer_mp          bus,
    input   logic               dma0_acknowledge_n,
    output  logic               timer_out,
    output  logic               drq0,
    output  xt_bus_pkg::data_t  chip_read_data,
    output  logic               chip_read_valid
);
    import xt_bus_pkg::*;

    logic   [15:0]  count;
    data_t          reload;
    logic           prev_timer_out;
    logic           port_hit;
    logic           load;

    assign port_hit = (bus.address == addr_t'(`XT_TIMER_PORT));
    assign load     = port_hit && (bus.cmd == CMD_IO_WRITE);

    // Down-counter, reloads on zero
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            count     <= 16'hFFFF;
            reload    <= '1;
            timer_out <= 1'b0;
        end
        else if (load)
        begin
            count  <= {8'h00, bus.write_data};
            reload <= bus.write_data;
        end
        else if (count == 16'h0000)
        begin
            count     <= {8'h00, reload};
            timer_out <= ~timer_out;
        end
        else
            count <= count - 16'd1;
    end

    // Request latch, cleared once channel 0 is acknowledged
    always_ff @(posedge clock or posedge reset)
    begin
        if (reset)
        begin
            prev_timer_out <= 1'b0;
            drq0           <= 1'b0;
        end
        else
        begin
            prev_timer_out <= timer_out;
            if (~dma0_acknowledge_n)
                drq0 <= 1'b0;
            else if (timer_out & ~prev_timer_out)
                drq0 <= 1'b1;
        end
    end

    assign chip_read_data  = count[7:0];
    assign chip_read_valid = port_hit && (bus.cmd == CMD_IO_READ);

endmodule

//--- verilog/xt_bus_if.sv
// One decoded CPU bus cycle, shared by the timer, arbiter and data steering
// The top level drives every signal from its ports
`timescale 1ns/1ns

interface xt_bus_if;
    import xt_bus_pkg::*;

    addr_t      address;
    logic       io_read_n;
    logic       io_write_n;
    logic       memory_read_n;
    logic       memory_write_n;
    data_t      write_data;
    bus_cmd_t   cmd;

    modport timer_mp
    (
        input   address,
        input   io_read_n,
        input   io_write_n,
        input   memory_read_n,
        input   memory_write_n,
        input   write_data,
        input   cmd
    );

    modport steer_mp (input address, input cmd);

    modport arb_mp (input cmd);

endinterface

//--- verilog/xt_bus_pkg.sv
// Types for CPU bus cycles
// Imported by every block that looks at an address, a data byte or a decoded cycle
`include "xt_chipset_cfg.svh"

package xt_bus_pkg;

    typedef logic [`XT_ADDR_W-1:0] addr_t;
    typedef logic [`XT_DATA_W-1:0] data_t;

    // One bus cycle kind, decoded from the active-low strobes
    typedef enum logic [2:0]
    {
        CMD_IDLE,
        CMD_IO_READ,
        CMD_IO_WRITE,
        CMD_MEM_READ,
        CMD_MEM_WRITE
    } bus_cmd_t;

    function automatic logic cmd_is_read(bus_cmd_t cmd);
        return (cmd == CMD_IO_READ) || (cmd == CMD_MEM_READ);
    endfunction

endpackage

//--- verilog/xt_chipset.sv
// Top level of the XT bus-control core
// Decodes the CPU strobes once and wires the timer, arbiter, ready and data steering
`timescale 1ns/1ns
`include "xt_chipset_cfg.svh"

module xt_chipset
(
    input   logic                   clock,
    input   logic                   reset,
    input   xt_bus_pkg::addr_t      address,
    input   xt_bus_pkg::data_t      data_bus_in,
    input   logic                   io_read_n,
    input   logic                   io_write_n,
    input   logic                   memory_read_n,
    input   logic                   memory_write_n,
    input   logic                   io_channel_ready,
    input   xt_dma_pkg::dma_vec_t   dma_request,
    output  xt_bus_pkg::data_t      data_bus_out,
    output  logic                   data_bus_direction,
    output  logic                   processor_ready,
    output  xt_dma_pkg::dma_vec_t   dma_acknowledge_n,
    output  logic                   address_enable_n,
    output  logic                   timer_out
);
    import xt_bus_pkg::*;
    import xt_dma_pkg::*;

    xt_bus_if   bus ();

    logic       drq0;
    logic       dma_wait;
    data_t      chip_read_data;
    logic       chip_read_valid;
    dma_vec_t   dma_request_merged;

    assign bus.address        = address;
    assign bus.io_read_n      = io_read_n;
    assign bus.io_write_n     = io_write_n;
    assign bus.memory_read_n  = memory_read_n;
    assign bus.memory_write_n = memory_write_n;
    assign bus.write_data     = data_bus_in;

    // Strobe decode, reads first
    always_comb
    begin
        if (~bus.io_read_n)
            bus.cmd = CMD_IO_READ;
        else if (~bus.io_write_n)
            bus.cmd = CMD_IO_WRITE;
        else if (~bus.memory_read_n)
            bus.cmd = CMD_MEM_READ;
        else if (~bus.memory_write_n)
            bus.cmd = CMD_MEM_WRITE;
        else
            bus.cmd = CMD_IDLE;
    end

    // Channel 0 belongs to refresh
    assign dma_request_merged = {dma_request[`XT_DMA_CH-1:1], drq0};

    refresh_timer u_refresh_timer
    (
        .clock              (clock),
        .reset              (reset),
        .bus                (bus.timer_mp),
        .dma0_acknowledge_n (dma_acknowledge_n[0]),
        .timer_out          (timer_out),
        .drq0               (drq0),
        .chip_read_data     (chip_read_data),
        .chip_read_valid    (chip_read_valid)
    );

    dma_arbiter u_dma_arbiter
    (
        .clock              (clock),
        .reset              (reset),
        .bus                (bus.arb_mp),
        .dma_request        (dma_request_merged),
        .dma_acknowledge_n  (dma_acknowledge_n),
        .address_enable_n   (address_enable_n),
        .dma_wait           (dma_wait)
    );

    ready_sync u_ready_sync
    (
        .clock              (clock),
        .reset              (reset),
        .io_channel_ready   (io_channel_ready),
        .dma_wait           (dma_wait),
        .processor_ready    (processor_ready)
    );

    data_bus_steer u_data_bus_steer
    (
        .bus                (bus.steer_mp),
        .chip_read_data     (chip_read_data),
        .chip_read_valid    (chip_read_valid),
        .data_bus_in        (data_bus_in),
        .data_bus_out       (data_bus_out),
        .data_bus_direction (data_bus_direction)
    );

endmodule

//--- verilog/xt_chipset_cfg.svh
// Build-time constants for the XT bus-control core
// Include wherever a width, port address or timing constant is needed
`ifndef XT_CHIPSET_CFG_SVH
`define XT_CHIPSET_CFG_SVH

// Bus widths
`define XT_ADDR_W 20
`define XT_DATA_W 8

// DMA channels and the clocks an acknowledge stays low
`define XT_DMA_CH 4
`define XT_DMA_CYCLES 4

// I/O address of the refresh timer
`define XT_TIMER_PORT 20'h00041

// Flop stages on io_channel_ready
`define XT_READY_SYNC 2

`endif

//--- verilog/xt_dma_pkg.sv
// Types for DMA channels and the bus arbiter
// Imported by the arbiter and the top level
`include "xt_chipset_cfg.svh"

package xt_dma_pkg;

    // One bit per channel, bit 0 is the refresh channel
    typedef logic [`XT_DMA_CH-1:0] dma_vec_t;

    // Channel number
    typedef logic [$clog2(`XT_DMA_CH)-1:0] dma_chan_t;

    // Bus ownership
    typedef enum logic [1:0]
    {
        DMA_IDLE,
        DMA_GRANT,
        DMA_RELEASE
    } dma_state_t;

endpackage
